// File: mp3_mem.f
verilog/rv32i_types.sv
verilog/line_port_if.sv
verilog/icache.sv
verilog/dcache.sv
verilog/arbiter.sv
verilog/mp3_mem.sv
verification/mp3_mem_assertions.sv
verification/mp3_mem_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module mp3_mem_tb \
		-f mp3_mem.f -Mdir obj_dir -o mp3_mem_sim

run: compile
	./obj_dir/mp3_mem_sim | tee sim.log
	grep -q "^\*\*\* TEST PASSED \*\*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/mp3_mem_tb.sv
`timescale 1ns/1ps

module mp3_mem_tb;

	localparam int reset_cycles = 8;
	// two fetches, two data accesses, one eviction, one fetch and data pair
	localparam int num_requests = 7;

	logic clk;
	logic rst;
	logic inst_read;
	rv32i_types::rv32i_word inst_addr;
	rv32i_types::rv32i_word inst_rdata;
	logic inst_resp;
	logic data_read;
	logic data_write;
	rv32i_types::rv32i_word data_addr;
	rv32i_types::rv32i_word data_wdata;
	rv32i_types::byte_en_t data_byte_enable;
	rv32i_types::rv32i_word data_rdata;
	logic data_resp;
	logic pmem_read;
	logic pmem_write;
	rv32i_types::rv32i_word pmem_address;
	rv32i_types::cache_line_t pmem_wdata;
	rv32i_types::cache_line_t pmem_rdata;
	logic pmem_resp;

	// lines written back by the DUT, and the expected memory image
	rv32i_types::cache_line_t pmem_model [rv32i_types::rv32i_word];
	rv32i_types::cache_line_t shadow [rv32i_types::rv32i_word];
	// one entry per completed pmem access
	bit log_write [$];
	rv32i_types::rv32i_word log_addr [$];
	rv32i_types::cache_line_t log_data [$];
	integer seed = 32'h0082_263c;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;

	mp3_mem #(.s_index (3)) mp3_mem_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// every word mixes all bits of its own address
	function automatic rv32i_types::cache_line_t line_init(input rv32i_types::rv32i_word addr);
		rv32i_types::cache_line_t l;
		rv32i_types::rv32i_word w;
		for (int i = 0; i < 8; i++) begin
			w = {addr[31:5], 5'b00000} + 4 * i;
			l[32*i +: 32] = {w[15:0], w[31:16]} ^ 32'ha5c3_0f96;
		end
		return l;
	endfunction

	function automatic rv32i_types::cache_line_t shadow_line(input rv32i_types::rv32i_word addr);
		rv32i_types::rv32i_word a;
		a = {addr[31:5], 5'b00000};
		return shadow.exists(a) ? shadow[a] : line_init(a);
	endfunction

	function automatic rv32i_types::rv32i_word shadow_word(input rv32i_types::rv32i_word addr);
		rv32i_types::cache_line_t l;
		l = shadow_line(addr);
		return l[{addr[4:2], 5'b00000} +: 32];
	endfunction

	// byte enable merge as the CPU sees it
	task automatic shadow_store(input rv32i_types::rv32i_word addr, input rv32i_types::rv32i_word
		wdata, input rv32i_types::byte_en_t be);
		rv32i_types::cache_line_t l;
		l = shadow_line(addr);
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				l[{addr[4:2], i[1:0], 3'b000} +: 8] = wdata[8*i +: 8];
		end
		shadow[{addr[31:5], 5'b00000}] = l;
	endtask

	// physical memory, latency 2 to 9 cycles from the grant
	initial begin
		int lat;
		forever begin
			@(posedge clk);
			#1;
			if (pmem_read || pmem_write) begin
				lat = 2 + ($unsigned($random(seed)) % 8);
				repeat (lat - 1) @(posedge clk);
				#1;
				pmem_rdata = pmem_model.exists(pmem_address) ? pmem_model[pmem_address]
					: line_init(pmem_address);
				if (pmem_write)
					pmem_model[pmem_address] = pmem_wdata;
				log_write.push_back(pmem_write);
				log_addr.push_back(pmem_address);
				log_data.push_back(pmem_wdata);
				pmem_resp = 1'b1;
				@(posedge clk);
				#1;
				pmem_resp = 1'b0;
			end
		end
	end

	task automatic check_word(input string name, input rv32i_types::rv32i_word got,
		input rv32i_types::rv32i_word exp);
		check_count++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_line(input string name, input rv32i_types::cache_line_t got,
		input rv32i_types::cache_line_t exp);
		check_count++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic expect_accesses(input int n);
		check_count++;
		if (log_addr.size() != n) begin
			$display("at %0t: expected %0d pmem accesses but saw %0d", $time, n, log_addr.size());
			error_count++;
		end
	endtask

	task automatic fetch(input rv32i_types::rv32i_word addr, output rv32i_types::rv32i_word data,
		output int cycles);
		inst_addr = addr;
		inst_read = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!inst_resp);
		data = inst_rdata;
		inst_read = 1'b0;
	endtask

	task automatic data_access(input logic wr, input rv32i_types::rv32i_word addr,
		input rv32i_types::rv32i_word wdata, input rv32i_types::byte_en_t be,
		output rv32i_types::rv32i_word data);
		data_addr = addr;
		data_wdata = wdata;
		data_byte_enable = be;
		data_write = wr;
		data_read = !wr;
		do begin
			@(posedge clk);
			#1;
		end while (!data_resp);
		data = data_rdata;
		data_read = 1'b0;
		data_write = 1'b0;
	endtask

	task automatic test_done(input string name, input int start);
		test_count++;
		$display("%s %s", name, (error_count == start) ? "passed" : "failed");
	endtask

	task automatic reset_test();
		int start;
		start = error_count;
		check_bit("inst_resp", inst_resp, 1'b0);
		check_bit("data_resp", data_resp, 1'b0);
		check_bit("pmem_read", pmem_read, 1'b0);
		check_bit("pmem_write", pmem_write, 1'b0);
		test_done("reset", start);
	endtask

	task automatic inst_test();
		int start;
		int cycles;
		rv32i_types::rv32i_word w;
		start = error_count;
		log_addr.delete();
		log_write.delete();
		fetch(32'h0000_1044, w, cycles);
		expect_accesses(1);
		check_bit("pmem_write", log_write[0], 1'b0);
		check_word("pmem_address", log_addr[0], 32'h0000_1040);
		check_word("inst_rdata", w, shadow_word(32'h0000_1044));
		// same line, so a hit
		fetch(32'h0000_1058, w, cycles);
		check_word("inst_rdata", w, shadow_word(32'h0000_1058));
		check_count++;
		if (cycles != 1) begin
			$display("at %0t: hit took %0d cycles instead of one", $time, cycles);
			error_count++;
		end
		test_done("instruction path", start);
	endtask

	task automatic data_test();
		int start;
		rv32i_types::rv32i_word w;
		start = error_count;
		data_access(1'b1, 32'h0000_2064, 32'hdead_beef, 4'b0110, w);
		shadow_store(32'h0000_2064, 32'hdead_beef, 4'b0110);
		data_access(1'b0, 32'h0000_2064, 32'h0, 4'b0000, w);
		check_word("data_rdata", w, shadow_word(32'h0000_2064));
		test_done("data path", start);
	endtask

	task automatic evict_test();
		int start;
		rv32i_types::rv32i_word w;
		start = error_count;
		log_addr.delete();
		log_write.delete();
		log_data.delete();
		// index 3 again with a new tag pushes out the dirty line
		data_access(1'b0, 32'h0000_3068, 32'h0, 4'b0000, w);
		expect_accesses(2);
		check_bit("pmem_write", log_write[0], 1'b1);
		check_word("pmem_address", log_addr[0], 32'h0000_2060);
		check_line("pmem_wdata", log_data[0], shadow_line(32'h0000_2060));
		check_bit("pmem_write", log_write[1], 1'b0);
		check_word("pmem_address", log_addr[1], 32'h0000_3060);
		check_word("data_rdata", w, shadow_word(32'h0000_3068));
		test_done("eviction", start);
	endtask

	task automatic arb_test();
		int start;
		int cycles;
		rv32i_types::rv32i_word iw;
		rv32i_types::rv32i_word dw;
		start = error_count;
		log_addr.delete();
		// both miss in the same cycle, data goes first
		fork
			fetch(32'h0000_50a4, iw, cycles);
			data_access(1'b0, 32'h0000_60c8, 32'h0, 4'b0000, dw);
		join
		check_word("pmem_address", log_addr[0], 32'h0000_60c0);
		check_word("inst_rdata", iw, shadow_word(32'h0000_50a4));
		check_word("data_rdata", dw, shadow_word(32'h0000_60c8));
		foreach (pmem_model[a])
			check_line($sformatf("pmem line %h", a), pmem_model[a], shadow_line(a));
		test_done("arbitration", start);
	endtask

	// bound on total run time
	initial begin
		#((reset_cycles + 200 * num_requests) * 10);
		$display("watchdog expired, a request never completed");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst = 1'b1;
		inst_read = 1'b0;
		inst_addr = '0;
		data_read = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		data_byte_enable = '0;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_test();
		inst_test();
		data_test();
		evict_test();
		arb_test();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule : mp3_mem_tb

// File: verification/mp3_mem_assertions.sv
`timescale 1ns/1ps

// handshake checks seen from the arbiter
module mp3_mem_assertions (
	input logic clk,
	input logic rst,
	input rv32i_types::arb_state_e state,
	input logic pmem_read,
	input logic pmem_write,
	input rv32i_types::rv32i_word pmem_address,
	input logic pmem_resp,
	input logic inst_req,
	input logic inst_resp,
	input logic data_req,
	input logic data_resp
);

	rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	// resp reaches only a port that still requests
	inst_resp_routed: assert property (@(posedge clk) disable iff (rst)
		inst_resp |-> inst_req)
		else $error("inst resp without a pending inst request");

	data_resp_routed: assert property (@(posedge clk) disable iff (rst)
		data_resp |-> data_req)
		else $error("data resp without a pending data request");

	// granted cache keeps its strobe up until the resp
	grant_held: assert property (@(posedge clk) disable iff (rst)
		(state != rv32i_types::arb_idle) |-> (pmem_read || pmem_write))
		else $error("grant active but the granted cache dropped its strobe");

	// held strobe keeps its address
	addr_stable: assert property (@(posedge clk) disable iff (rst)
		(pmem_read || pmem_write) && !pmem_resp |=> $stable(pmem_address))
		else $error("pmem_address changed while a strobe was held");

	quiet_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !pmem_read && !pmem_write && !inst_resp && !data_resp)
		else $error("strobe or resp high right after reset");

endmodule : mp3_mem_assertions

bind arbiter mp3_mem_assertions arbiter_assertions (
	.clk          (clk),
	.rst          (rst),
	.state        (state),
	.pmem_read    (pmem_read),
	.pmem_write   (pmem_write),
	.pmem_address (pmem_address),
	.pmem_resp    (pmem_resp),
	.inst_req     (inst_req),
	.inst_resp    (inst_port.resp),
	.data_req     (data_req),
	.data_resp    (data_port.resp)
);

// File: verilog/mp3_mem.sv
`timescale 1ns/1ps

module mp3_mem #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,

	// instruction fetch port
	input logic inst_read,
	input rv32i_types::rv32i_word inst_addr,
	output rv32i_types::rv32i_word inst_rdata,
	output logic inst_resp,

	// memory stage port
	input logic data_read,
	input logic data_write,
	input rv32i_types::rv32i_word data_addr,
	input rv32i_types::rv32i_word data_wdata,
	input rv32i_types::byte_en_t data_byte_enable,
	output rv32i_types::rv32i_word data_rdata,
	output logic data_resp,

	// physical memory, one line per access
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_types::rv32i_word pmem_address,
	output rv32i_types::cache_line_t pmem_wdata,
	input rv32i_types::cache_line_t pmem_rdata,
	input logic pmem_resp
);

	// cache to arbiter links
	line_port_if inst_line ();
	line_port_if data_line ();

	icache #(
		.s_index (s_index)
	) icache (
		.clk         (clk),
		.rst         (rst),
		.mem_read    (inst_read),
		.mem_address (inst_addr),
		.mem_rdata   (inst_rdata),
		.mem_resp    (inst_resp),
		.mem_port    (inst_line)
	);

	dcache #(
		.s_index (s_index)
	) dcache (
		.clk             (clk),
		.rst             (rst),
		.mem_read        (data_read),
		.mem_write       (data_write),
		.mem_address     (data_addr),
		.mem_wdata       (data_wdata),
		.mem_byte_enable (data_byte_enable),
		.mem_rdata       (data_rdata),
		.mem_resp        (data_resp),
		.mem_port        (data_line)
	);

	// both misses may be pending, arbiter serializes them
	arbiter arbiter (
		.clk          (clk),
		.rst          (rst),
		.inst_port    (inst_line),
		.data_port    (data_line),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

endmodule : mp3_mem

// File: verilog/arbiter.sv
`timescale 1ns/1ps

module arbiter (
	input logic clk,
	input logic rst,
	line_port_if.arb inst_port,
	line_port_if.arb data_port,
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_types::rv32i_word pmem_address,
	output rv32i_types::cache_line_t pmem_wdata,
	input rv32i_types::cache_line_t pmem_rdata,
	input logic pmem_resp
);

	rv32i_types::arb_state_e state;
	rv32i_types::arb_state_e next_state;
	logic inst_req;
	logic data_req;

	// either strobe counts as a pending request
	assign inst_req = inst_port.read || inst_port.write;
	assign data_req = data_port.read || data_port.write;

	// grant one port per transaction
	always_comb begin
		next_state = state;
		unique case (state)
			rv32i_types::arb_idle: begin
				// data wins a tie
				if (data_req)
					next_state = rv32i_types::arb_data;
				else if (inst_req)
					next_state = rv32i_types::arb_inst;
			end
			rv32i_types::arb_inst, rv32i_types::arb_data: begin
				// release after the single resp cycle
				if (pmem_resp)
					next_state = rv32i_types::arb_idle;
			end
			default: begin
				next_state = rv32i_types::arb_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= rv32i_types::arb_idle;
		else
			state <= next_state;
	end

	// mux granted request onto pmem, route reply back
	always_comb begin
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_address = '0;
		pmem_wdata = '0;
		inst_port.rdata = '0;
		inst_port.resp = 1'b0;
		data_port.rdata = '0;
		data_port.resp = 1'b0;
		unique case (state)
			rv32i_types::arb_inst: begin
				pmem_read = inst_port.read;
				pmem_write = inst_port.write;
				pmem_address = inst_port.address;
				pmem_wdata = inst_port.wdata;
				// resp passes straight through in the same cycle
				inst_port.rdata = pmem_rdata;
				inst_port.resp = pmem_resp;
			end
			rv32i_types::arb_data: begin
				pmem_read = data_port.read;
				pmem_write = data_port.write;
				pmem_address = data_port.address;
				pmem_wdata = data_port.wdata;
				data_port.rdata = pmem_rdata;
				data_port.resp = pmem_resp;
			end
			default: begin
				// idle, pmem stays quiet
			end
		endcase
	end

endmodule : arbiter

// File: verilog/dcache.sv
`timescale 1ns/1ps

module dcache #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input rv32i_types::rv32i_word mem_address,
	input rv32i_types::rv32i_word mem_wdata,
	input rv32i_types::byte_en_t mem_byte_enable,
	output rv32i_types::rv32i_word mem_rdata,
	output logic mem_resp,
	line_port_if.cache mem_port
);

	localparam int s_tag = 32 - s_index - rv32i_types::offset_bits;
	localparam int num_sets = 2 ** s_index;

	// fields of the cpu address
	logic [s_tag-1:0] addr_tag;
	logic [s_index-1:0] addr_index;
	logic [rv32i_types::word_sel_bits-1:0] addr_word;

	// per set storage
	logic [s_tag-1:0] tag_arr [num_sets];
	rv32i_types::cache_line_t line_arr [num_sets];
	logic [num_sets-1:0] valid_q;
	logic [num_sets-1:0] dirty_q;

	rv32i_types::cache_state_e state;
	rv32i_types::cache_state_e next_state;
	logic access;
	logic hit;
	logic victim_dirty;
	logic write_hit;
	logic fill_done;

	assign addr_tag = mem_address[31 -: s_tag];
	assign addr_index = mem_address[rv32i_types::offset_bits +: s_index];
	assign addr_word = mem_address[rv32i_types::byte_sel_bits +: rv32i_types::word_sel_bits];

	assign access = mem_read || mem_write;
	assign hit = valid_q[addr_index] && (tag_arr[addr_index] == addr_tag);
	// only a valid dirty line needs to go back to memory
	assign victim_dirty = valid_q[addr_index] && dirty_q[addr_index];

	assign write_hit = (state == rv32i_types::idle) && mem_write && hit;
	assign fill_done = (state == rv32i_types::fill) && mem_port.resp;

	// line port requests follow the state
	assign mem_port.read = (state == rv32i_types::fill);
	assign mem_port.write = (state == rv32i_types::writeback);
	// victim goes out whole
	assign mem_port.wdata = line_arr[addr_index];

	// writeback targets the old line, rebuilt from the stored tag
	always_comb begin
		if (state == rv32i_types::writeback)
			mem_port.address = {tag_arr[addr_index], addr_index,
				{rv32i_types::offset_bits{1'b0}}};
		else
			mem_port.address = {addr_tag, addr_index,
				{rv32i_types::offset_bits{1'b0}}};
	end

	// next state
	always_comb begin
		next_state = state;
		unique case (state)
			rv32i_types::idle: begin
				if (access && !hit) begin
					// clean or empty victim can be overwritten at once
					if (victim_dirty)
						next_state = rv32i_types::writeback;
					else
						next_state = rv32i_types::fill;
				end
			end
			rv32i_types::writeback: begin
				if (mem_port.resp)
					next_state = rv32i_types::fill;
			end
			rv32i_types::fill: begin
				// the original access then hits
				if (mem_port.resp)
					next_state = rv32i_types::idle;
			end
			default: begin
				next_state = rv32i_types::idle;
			end
		endcase
	end

	// control state, valid and dirty bits
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rv32i_types::idle;
			valid_q <= '0;
			dirty_q <= '0;
			mem_resp <= 1'b0;
		end else begin
			state <= next_state;
			mem_resp <= (state == rv32i_types::idle) && access && hit;
			// fresh line is clean
			if (fill_done) begin
				valid_q[addr_index] <= 1'b1;
				dirty_q[addr_index] <= 1'b0;
			end
			if (write_hit)
				dirty_q[addr_index] <= 1'b1;
		end
	end

	// tags, lines and read data
	always_ff @(posedge clk) begin
		if (fill_done) begin
			line_arr[addr_index] <= mem_port.rdata;
			tag_arr[addr_index] <= addr_tag;
		end
		// merge only the enabled bytes of the selected word
		if (write_hit) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_byte_enable[i])
					line_arr[addr_index][{addr_word, i[1:0], 3'b000} +: 8] <=
						mem_wdata[8*i +: 8];
			end
		end
		// word as stored before any merge
		if ((state == rv32i_types::idle) && access && hit)
			mem_rdata <= line_arr[addr_index][{addr_word, 5'b00000} +: 32];
	end

endmodule : dcache

// File: verilog/icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input rv32i_types::rv32i_word mem_address,
	output rv32i_types::rv32i_word mem_rdata,
	output logic mem_resp,
	line_port_if.cache mem_port
);

	// tag gets whatever is left above index and offset
	localparam int s_tag = 32 - s_index - rv32i_types::offset_bits;
	localparam int num_sets = 2 ** s_index;

	// fields of the fetch address
	logic [s_tag-1:0] addr_tag;
	logic [s_index-1:0] addr_index;
	logic [rv32i_types::word_sel_bits-1:0] addr_word;

	// per set storage
	logic [s_tag-1:0] tag_arr [num_sets];
	rv32i_types::cache_line_t line_arr [num_sets];
	logic [num_sets-1:0] valid_q;

	rv32i_types::cache_state_e state;
	rv32i_types::cache_state_e next_state;
	logic hit;
	logic fill_done;

	assign addr_tag = mem_address[31 -: s_tag];
	assign addr_index = mem_address[rv32i_types::offset_bits +: s_index];
	assign addr_word = mem_address[rv32i_types::byte_sel_bits +: rv32i_types::word_sel_bits];

	// direct mapped lookup
	assign hit = valid_q[addr_index] && (tag_arr[addr_index] == addr_tag);

	// returned line arrives with the resp pulse
	assign fill_done = (state == rv32i_types::fill) && mem_port.resp;

	// read only, so the port never writes
	assign mem_port.read = (state == rv32i_types::fill);
	assign mem_port.write = 1'b0;
	assign mem_port.wdata = '0;
	// cpu holds the address, so this stays put for the whole fill
	assign mem_port.address = {addr_tag, addr_index, {rv32i_types::offset_bits{1'b0}}};

	// next state
	always_comb begin
		next_state = state;
		unique case (state)
			rv32i_types::idle: begin
				// miss starts a fill
				if (mem_read && !hit)
					next_state = rv32i_types::fill;
			end
			rv32i_types::fill: begin
				// back to idle, lookup repeats as a hit
				if (mem_port.resp)
					next_state = rv32i_types::idle;
			end
			default: begin
				next_state = rv32i_types::idle;
			end
		endcase
	end

	// control state
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rv32i_types::idle;
			valid_q <= '0;
			mem_resp <= 1'b0;
		end else begin
			state <= next_state;
			// hit answers one cycle after the request is sampled
			mem_resp <= (state == rv32i_types::idle) && mem_read && hit;
			if (fill_done)
				valid_q[addr_index] <= 1'b1;
		end
	end

	// tags, lines and read data
	always_ff @(posedge clk) begin
		if (fill_done) begin
			line_arr[addr_index] <= mem_port.rdata;
			tag_arr[addr_index] <= addr_tag;
		end
		// pick one word out of the line
		if ((state == rv32i_types::idle) && mem_read && hit)
			mem_rdata <= line_arr[addr_index][{addr_word, 5'b00000} +: 32];
	end

endmodule : icache

// File: verilog/line_port_if.sv
`timescale 1ns/1ps

// line traffic between one cache and the arbiter
// strobes held until a one-cycle resp
interface line_port_if;

	// request side, driven by the cache
	logic read;
	logic write;
	// always line aligned
	rv32i_types::rv32i_word address;
	rv32i_types::cache_line_t wdata;

	// response side, driven by the arbiter
	rv32i_types::cache_line_t rdata;
	logic resp;

	modport cache (
		output read, write, address, wdata,
		input rdata, resp
	);

	modport arb (
		input read, write, address, wdata,
		output rdata, resp
	);

endinterface : line_port_if

// File: verilog/rv32i_types.sv
package rv32i_types;

	// basic word for addresses and data on the cpu side
	typedef logic [31:0] rv32i_word;

	// one cache line, eight words
	typedef logic [255:0] cache_line_t;

	// one bit per byte of a word
	typedef logic [3:0] byte_en_t;

	// address fields below the index
	// byte offset within a line
	localparam int offset_bits = 5;
	// byte within a word
	localparam int byte_sel_bits = 2;
	// word within a line
	localparam int word_sel_bits = offset_bits - byte_sel_bits;

	// cache controller states
	// writeback only reachable in the data cache
	typedef enum logic [1:0] {
		idle,
		writeback,
		fill
	} cache_state_e;

	// arbiter grant states
	typedef enum logic [1:0] {
		arb_idle,
		arb_inst,
		arb_data
	} arb_state_e;

endpackage : rv32i_types
